// ==== logic/scdPkg.sv ====
`default_nettype none

package scdPkg;

  localparam int scadWidth = 10;
  localparam int arWidth = 36;
  localparam int magicWidth = 9;

  // Shift counts at or past a full word
  localparam int unsigned scGe36Limit = 36;

  // Microcoded SCAD functions
  typedef enum logic [2:0] {
    funcA             = 3'd0,
    funcAMinusBMinus1 = 3'd1,
    funcAPlusB        = 3'd2,
    funcAMinus1       = 3'd3,
    funcAPlus1        = 3'd4,
    funcAMinusB       = 3'd5,
    funcOr            = 3'd6,
    funcAnd           = 3'd7
  } ScadFunc;

  // Codes 4 to 7 leave the A operand at zero
  typedef enum logic [2:0] {
    aFe    = 3'd0,
    aArPos = 3'd1,
    aArExp = 3'd2,
    aMagic = 3'd3
  } ScadASel;

  typedef enum logic [1:0] {
    bSc       = 2'd0,
    bArSize   = 2'd1,
    bArExpRaw = 2'd2,
    bMagic    = 2'd3
  } ScadBSel;

  typedef enum logic [1:0] {
    scHold    = 2'd0,
    scFe      = 2'd1,
    scScad    = 2'd2,
    scArRight = 2'd3
  } ScSel;

  // AR bits 0 to 12 as a floating-point word
  typedef struct packed {
    logic       sign;
    logic [0:7] exponent;
    logic [0:3] rest;
  } ArExpView;

  // AR bits 0 to 12 as saved PC flags
  typedef struct packed {
    logic ov;
    logic cry0;
    logic cry1;
    logic fov;
    logic fpd;
    logic user;
    logic userIot;
    logic public;
    logic adrBrkInh;
    logic trapReq2;
    logic trapReq1;
    logic fxu;
    logic divChk;
  } ArFlagsView;

  typedef union packed {
    ArExpView   expView;
    ArFlagsView flagView;
  } ArLeft;

endpackage

`default_nettype wire

// ==== logic/scdCtlIf.sv ====
`timescale 1ns/1ns
`default_nettype none

interface scdCtlIf;

  // SCAD and shift count fields of the microword
  scdPkg::ScadFunc scadFunc;
  scdPkg::ScadASel scadASel;
  scdPkg::ScadBSel scadBSel;
  logic [0:scdPkg::magicWidth-1] magic;
  logic feLoad;
  scdPkg::ScSel scSel;

  // Flag conditions
  logic setAdFlags;
  logic loadFlags;
  logic expTest;
  logic pcfMagic;
  logic clrFpd;
  logic piCycle;

  modport select (input scadASel, scadBSel, magic);
  modport adder (input scadFunc);
  modport regs (input feLoad, scSel);
  modport flags (input setAdFlags, loadFlags, expTest, pcfMagic, clrFpd, piCycle, magic);

endinterface

`default_nettype wire

// ==== logic/scadOperandSelect.sv ====
`timescale 1ns/1ns
`default_nettype none

module scadOperandSelect (
  scdCtlIf.select ctl,
  input  wire logic [0:scdPkg::arWidth-1]   ar,
  input  wire logic [0:scdPkg::scadWidth-1] fe,
  input  wire logic [0:scdPkg::scadWidth-1] sc,
  output logic      [0:scdPkg::scadWidth-1] opA,
  output logic      [0:scdPkg::scadWidth-1] opB
);

  scdPkg::ArLeft arLeft;
  logic [0:scdPkg::scadWidth-1] magicExt;
  logic [0:scdPkg::scadWidth-1] arExpA;

  assign arLeft = ar[0:12];

  assign magicExt = {{(scdPkg::scadWidth - scdPkg::magicWidth){ctl.magic[0]}}, ctl.magic};

  // Ones-complement the exponent of a negative number
  assign arExpA = {2'b00, arLeft.expView.exponent ^ {8{arLeft.expView.sign}}};

  always_comb begin
    case (ctl.scadASel)
      scdPkg::aFe:    opA = fe;
      scdPkg::aArPos: opA = {4'b0000, ar[0:5]};
      scdPkg::aArExp: opA = arExpA;
      scdPkg::aMagic: opA = magicExt;
      default:        opA = '0;
    endcase
  end

  always_comb begin
    case (ctl.scadBSel)
      scdPkg::bSc:       opB = sc;
      scdPkg::bArSize:   opB = {4'b0000, ar[6:11]};
      scdPkg::bArExpRaw: opB = {1'b0, arLeft.expView.sign, arLeft.expView.exponent};
      default:           opB = magicExt;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/scadAdder.sv ====
`timescale 1ns/1ns
`default_nettype none

module scadAdder (
  scdCtlIf.adder ctl,
  input  wire logic [0:scdPkg::scadWidth-1] opA,
  input  wire logic [0:scdPkg::scadWidth-1] opB,
  output logic      [0:scdPkg::scadWidth-1] scad,
  output logic                              scadZero
);

  logic [0:scdPkg::scadWidth-1] addB;
  logic                         cin;
  logic [0:scdPkg::scadWidth-1] sum;

  // B side and carry-in of the adder for each function
  always_comb begin
    addB = '0;
    cin = 1'b0;
    case (ctl.scadFunc)
      scdPkg::funcAMinusBMinus1: addB = ~opB;
      scdPkg::funcAPlusB:        addB = opB;
      scdPkg::funcAMinus1:       addB = '1;
      scdPkg::funcAPlus1:        cin = 1'b1;
      scdPkg::funcAMinusB: begin
        addB = ~opB;
        cin = 1'b1;
      end
      default: ;
    endcase
  end

  // Wraps modulo 1024
  assign sum = opA + addB + {{(scdPkg::scadWidth-1){1'b0}}, cin};

  always_comb begin
    case (ctl.scadFunc)
      scdPkg::funcOr:  scad = opA | opB;
      scdPkg::funcAnd: scad = opA & opB;
      default:         scad = sum;
    endcase
  end

  assign scadZero = (scad == '0);

endmodule

`default_nettype wire

// ==== logic/shiftCountRegs.sv ====
`timescale 1ns/1ns
`default_nettype none

module shiftCountRegs (
  input  wire logic                         clk,
  input  wire logic                         reset,
  scdCtlIf.regs ctl,
  input  wire logic [0:scdPkg::arWidth-1]   ar,
  input  wire logic [0:scdPkg::scadWidth-1] scad,
  output logic      [0:scdPkg::scadWidth-1] fe,
  output logic      [0:scdPkg::scadWidth-1] sc,
  output logic                              scGe36
);

  logic [0:scdPkg::scadWidth-1] scNext;

  // SC source mux
  always_comb begin
    case (ctl.scSel)
      scdPkg::scFe:      scNext = fe;
      scdPkg::scScad:    scNext = scad;
      scdPkg::scArRight: scNext = {ar[18], ar[18], ar[28:35]};
      default:           scNext = sc;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      fe <= '0;
    end else if (ctl.feLoad) begin
      fe <= scad;
    end
  end

  // Range decode follows SC into the same edge; negative counts read as large
  always_ff @(posedge clk) begin
    if (reset) begin
      sc <= '0;
      scGe36 <= 1'b0;
    end else begin
      sc <= scNext;
      scGe36 <= (scNext >= scdPkg::scGe36Limit);
    end
  end

endmodule

`default_nettype wire

// ==== logic/arithFlags.sv ====
`timescale 1ns/1ns
`default_nettype none

module arithFlags (
  input  wire logic                         clk,
  input  wire logic                         reset,
  scdCtlIf.flags ctl,
  input  wire logic [0:scdPkg::arWidth-1]   ar,
  input  wire logic [0:scdPkg::scadWidth-1] scad,
  input  wire logic                         adOv,
  input  wire logic                         adCry0,
  input  wire logic                         adCry1,
  output logic                              ov,
  output logic                              cry0,
  output logic                              cry1,
  output logic                              fov,
  output logic                              fxu,
  output logic                              divChk,
  output logic                              fpd
);

  scdPkg::ArLeft arLeft;
  logic adSet;
  logic expSet;
  logic magSet;
  logic ovSet;
  logic fovSet;
  logic fxuSet;
  logic fpdSet;

  assign arLeft = ar[0:12];

  // No flag sets during a PI cycle
  assign adSet = ctl.setAdFlags & ~ctl.piCycle;
  assign expSet = ctl.expTest & ~ctl.piCycle;
  assign magSet = ctl.pcfMagic & ~ctl.piCycle;

  assign ovSet = adSet & adOv | expSet & (scad[0] | scad[1]) | magSet & ctl.magic[0];
  assign fovSet = expSet & (scad[0] | scad[1]) | magSet & ctl.magic[0];
  assign fxuSet = expSet & scad[0] | magSet & ctl.magic[5];
  assign fpdSet = magSet & ctl.magic[2];

  always_ff @(posedge clk) begin
    if (reset) begin
      ov <= 1'b0;
      cry0 <= 1'b0;
      cry1 <= 1'b0;
      fov <= 1'b0;
      fxu <= 1'b0;
      divChk <= 1'b0;
      fpd <= 1'b0;
    end else if (ctl.loadFlags) begin
      ov <= arLeft.flagView.ov;
      cry0 <= arLeft.flagView.cry0;
      cry1 <= arLeft.flagView.cry1;
      fov <= arLeft.flagView.fov;
      fxu <= arLeft.flagView.fxu;
      divChk <= arLeft.flagView.divChk;
      fpd <= arLeft.flagView.fpd;
    end else begin
      // Sticky until reloaded
      ov <= ov | ovSet;
      cry0 <= cry0 | adSet & adCry0;
      cry1 <= cry1 | adSet & adCry1;
      fov <= fov | fovSet;
      fxu <= fxu | fxuSet;
      divChk <= divChk | magSet & ctl.magic[6];
      // A set in the same cycle wins over the clear
      fpd <= fpdSet | fpd & ~ctl.clrFpd;
    end
  end

endmodule

`default_nettype wire

// ==== logic/scdTop.sv ====
`timescale 1ns/1ns
`default_nettype none

module scdTop (
  input  wire logic                          clk,
  input  wire logic                          reset,
  input  wire logic [0:scdPkg::arWidth-1]    ar,
  input  wire logic [0:scdPkg::magicWidth-1] magic,
  input  wire scdPkg::ScadFunc               scadFunc,
  input  wire scdPkg::ScadASel               scadASel,
  input  wire scdPkg::ScadBSel               scadBSel,
  input  wire logic                          feLoad,
  input  wire scdPkg::ScSel                  scSel,
  input  wire logic                          setAdFlags,
  input  wire logic                          adOv,
  input  wire logic                          adCry0,
  input  wire logic                          adCry1,
  input  wire logic                          loadFlags,
  input  wire logic                          expTest,
  input  wire logic                          pcfMagic,
  input  wire logic                          clrFpd,
  input  wire logic                          piCycle,
  output logic      [0:scdPkg::scadWidth-1]  scad,
  output logic                               scadZero,
  output logic      [0:scdPkg::scadWidth-1]  fe,
  output logic      [0:scdPkg::scadWidth-1]  sc,
  output logic                               scGe36,
  output logic                               ov,
  output logic                               cry0,
  output logic                               cry1,
  output logic                               fov,
  output logic                               fxu,
  output logic                               divChk,
  output logic                               fpd
);

  logic [0:scdPkg::scadWidth-1] opA;
  logic [0:scdPkg::scadWidth-1] opB;

  scdCtlIf ctl ();

  assign ctl.scadFunc = scadFunc;
  assign ctl.scadASel = scadASel;
  assign ctl.scadBSel = scadBSel;
  assign ctl.magic = magic;
  assign ctl.feLoad = feLoad;
  assign ctl.scSel = scSel;
  assign ctl.setAdFlags = setAdFlags;
  assign ctl.loadFlags = loadFlags;
  assign ctl.expTest = expTest;
  assign ctl.pcfMagic = pcfMagic;
  assign ctl.clrFpd = clrFpd;
  assign ctl.piCycle = piCycle;

  scadOperandSelect scadOperandSelect_i (
    .ctl(ctl.select), .ar(ar), .fe(fe), .sc(sc), .opA(opA), .opB(opB)
  );

  scadAdder scadAdder_i (
    .ctl(ctl.adder), .opA(opA), .opB(opB), .scad(scad), .scadZero(scadZero)
  );

  shiftCountRegs shiftCountRegs_i (
    .clk(clk), .reset(reset), .ctl(ctl.regs), .ar(ar), .scad(scad),
    .fe(fe), .sc(sc), .scGe36(scGe36)
  );

  arithFlags arithFlags_i (
    .clk(clk), .reset(reset), .ctl(ctl.flags), .ar(ar), .scad(scad),
    .adOv(adOv), .adCry0(adCry0), .adCry1(adCry1),
    .ov(ov), .cry0(cry0), .cry1(cry1), .fov(fov), .fxu(fxu),
    .divChk(divChk), .fpd(fpd)
  );

endmodule

`default_nettype wire

// ==== dv/scd_assertions.sv ====
`timescale 1ns/1ns
`default_nettype none

module scdAssertions (
  input wire logic                         clk,
  input wire logic                         reset,
  input wire logic [0:scdPkg::arWidth-1]   ar,
  input wire logic                         loadFlags,
  input wire logic [0:scdPkg::scadWidth-1] scad,
  input wire logic                         scadZero,
  input wire logic [0:scdPkg::scadWidth-1] fe,
  input wire logic [0:scdPkg::scadWidth-1] sc,
  input wire logic                         scGe36, ov, cry0, cry1, fov, fxu, divChk, fpd
);

  int unsigned failureCount = 0;

  zeroDetect: assert property (@(posedge clk) disable iff (reset) scadZero == (scad == '0))
    else begin
      failureCount++;
      $error("scadZero disagrees with SCAD output %h", scad);
    end

  resetClears: assert property (@(posedge clk) reset |=>
      fe == '0 && sc == '0 && !scGe36 && !ov && !cry0 && !cry1 &&
      !fov && !fxu && !divChk && !fpd)
    else begin
      failureCount++;
      $error("registered outputs not cleared one cycle after reset");
    end

  // OV and FPD sit at AR bits 0 and 4 of the flags word
  flagLoad: assert property (@(posedge clk) disable iff (reset)
      loadFlags |=> ov == $past(ar[0]) && fpd == $past(ar[4]))
    else begin
      failureCount++;
      $error("OV or FPD did not load from AR");
    end

endmodule

bind scdTop scdAssertions scdAssertions_i (
  .clk(clk), .reset(reset), .ar(ar), .loadFlags(loadFlags), .scad(scad),
  .scadZero(scadZero), .fe(fe), .sc(sc), .scGe36(scGe36), .ov(ov), .cry0(cry0),
  .cry1(cry1), .fov(fov), .fxu(fxu), .divChk(divChk), .fpd(fpd)
);

`default_nettype wire

// ==== dv/scdTopTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module scdTopTb;

  // The tests take about 600 cycles
  localparam int cycleLimit = 2000;

  logic clk = 1'b0;
  logic reset = 1'b1;
  logic [0:scdPkg::arWidth-1] ar;
  logic [0:scdPkg::magicWidth-1] magic;
  scdPkg::ScadFunc scadFunc;
  scdPkg::ScadASel scadASel;
  scdPkg::ScadBSel scadBSel;
  scdPkg::ScSel scSel;
  logic feLoad, setAdFlags, adOv, adCry0, adCry1, loadFlags, expTest, pcfMagic, clrFpd, piCycle;
  logic [0:scdPkg::scadWidth-1] scad, fe, sc;
  logic scadZero, scGe36, ov, cry0, cry1, fov, fxu, divChk, fpd;
  int cycleCount = 0;

  scdTop scdTop_i (.*);

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      failRun("the run reached the cycle limit before the tests finished");
    end
  end

  task automatic failRun(input string reason);
    $display("Test failed");
    $fatal(1, "%s", reason);
  endtask

  task automatic checkWord(input string name, input logic [0:scdPkg::scadWidth-1] expected,
                           input logic [0:scdPkg::scadWidth-1] actual);
    if (actual !== expected) begin
      $display("Error %s: expected %h, actual %h", name, expected, actual);
      failRun("a ten-bit word did not match");
    end
  endtask

  task automatic checkFlag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("Error %s: expected %b, actual %b", name, expected, actual);
      failRun("an arithmetic flag did not match");
    end
  endtask

  // scadZero and scGe36
  task automatic checkDecode(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("Error %s: expected %b, actual %b", name, expected, actual);
      failRun("a decoded status bit did not match");
    end
  endtask

  // Order is ov, cry0, cry1, fov, fxu, divChk, fpd
  task automatic checkFlags(input string name, input logic [0:6] expected);
    checkFlag({name, " ov"}, expected[0], ov);
    checkFlag({name, " cry0"}, expected[1], cry0);
    checkFlag({name, " cry1"}, expected[2], cry1);
    checkFlag({name, " fov"}, expected[3], fov);
    checkFlag({name, " fxu"}, expected[4], fxu);
    checkFlag({name, " divChk"}, expected[5], divChk);
    checkFlag({name, " fpd"}, expected[6], fpd);
  endtask

  function automatic logic [0:9] scadExpected(input scdPkg::ScadFunc f, input logic [0:9] a, b);
    case (f)
      scdPkg::funcAMinusBMinus1: return a - b - 10'd1;
      scdPkg::funcAPlusB:        return a + b;
      scdPkg::funcAMinus1:       return a - 10'd1;
      scdPkg::funcAPlus1:        return a + 10'd1;
      scdPkg::funcAMinusB:       return a - b;
      scdPkg::funcOr:            return a | b;
      scdPkg::funcAnd:           return a & b;
      default:                   return a;
    endcase
  endfunction

  function automatic logic [0:9] signExtend(input logic [0:8] m);
    return {m[0], m};
  endfunction

  function automatic logic geExpected(input logic [0:9] v);
    return 32'(v) >= scdPkg::scGe36Limit;
  endfunction

  task automatic nextCycle();
    @(posedge clk);
    #1;
  endtask

  task automatic clearControls();
    ar = '0;
    magic = '0;
    scadFunc = scdPkg::funcA;
    scadASel = scdPkg::aFe;
    scadBSel = scdPkg::bSc;
    scSel = scdPkg::scHold;
    feLoad = 1'b0;
    setAdFlags = 1'b0;
    adOv = 1'b0;
    adCry0 = 1'b0;
    adCry1 = 1'b0;
    loadFlags = 1'b0;
    expTest = 1'b0;
    pcfMagic = 1'b0;
    clrFpd = 1'b0;
    piCycle = 1'b0;
  endtask

  task automatic clearFlags();
    ar = '0;
    loadFlags = 1'b1;
    nextCycle();
    loadFlags = 1'b0;
  endtask

  task automatic testFunctions();
    logic [0:9] expected;
    scadASel = scdPkg::aArPos;
    scadBSel = scdPkg::bArSize;
    for (int i = 0; i < 512; i++) begin
      scadFunc = scdPkg::ScadFunc'(3'(i));
      ar = {4'($urandom()), $urandom()};
      // Equal position and size give a zero A-B
      if (i % 64 == 5) begin
        ar[6:11] = ar[0:5];
      end
      #1;
      expected = scadExpected(scadFunc, {4'b0000, ar[0:5]}, {4'b0000, ar[6:11]});
      checkWord("functions scad", expected, scad);
      checkDecode("functions scadZero", expected == '0, scadZero);
      nextCycle();
    end
  endtask

  task automatic testOperands();
    logic [0:9] scLoaded;
    magic = 9'h1A5;
    scadASel = scdPkg::aMagic;
    scadFunc = scdPkg::funcA;
    feLoad = 1'b1;
    ar = {4'($urandom()), $urandom()};
    scSel = scdPkg::scArRight;
    scLoaded = {ar[18], ar[18], ar[28:35]};
    nextCycle();
    feLoad = 1'b0;
    scSel = scdPkg::scHold;
    checkWord("operands fe", signExtend(9'h1A5), fe);
    checkWord("operands sc", scLoaded, sc);
    scadASel = scdPkg::aFe;
    scadBSel = scdPkg::bSc;
    scadFunc = scdPkg::funcAPlusB;
    #1;
    checkWord("operands fe+sc", scadExpected(scadFunc, signExtend(9'h1A5), scLoaded), scad);
    nextCycle();
    scadASel = scdPkg::aArExp;
    scadFunc = scdPkg::funcA;
    ar[0] = 1'b1;
    #1;
    checkWord("operands negative exponent", {2'b00, ~ar[1:8]}, scad);
    nextCycle();
    ar[0] = 1'b0;
    #1;
    checkWord("operands positive exponent", {2'b00, ar[1:8]}, scad);
    nextCycle();
    scadASel = scdPkg::aMagic;
    scadBSel = scdPkg::bArExpRaw;
    scadFunc = scdPkg::funcAPlusB;
    #1;
    checkWord("operands magic+arExpRaw", signExtend(magic) + {1'b0, ar[0:8]}, scad);
    nextCycle();
  endtask

  task automatic testScSources();
    logic [0:8] counts [4] = '{9'd35, 9'd36, 9'd64, 9'h1F0};
    scadASel = scdPkg::aMagic;
    scadFunc = scdPkg::funcA;
    scSel = scdPkg::scScad;
    foreach (counts[i]) begin
      magic = counts[i];
      nextCycle();
      checkWord("sc from scad", signExtend(counts[i]), sc);
      checkDecode("scGe36 from scad", geExpected(signExtend(counts[i])), scGe36);
    end
    magic = 9'd20;
    feLoad = 1'b1;
    scSel = scdPkg::scHold;
    nextCycle();
    checkWord("sc hold", signExtend(9'h1F0), sc);
    feLoad = 1'b0;
    scSel = scdPkg::scFe;
    nextCycle();
    checkWord("sc from fe", 10'd20, sc);
    checkDecode("scGe36 from fe", 1'b0, scGe36);
    ar = {4'($urandom()), $urandom()};
    ar[18] = 1'b1;
    scSel = scdPkg::scArRight;
    nextCycle();
    checkWord("sc from arRight", {2'b11, ar[28:35]}, sc);
    checkDecode("scGe36 negative", 1'b1, scGe36);
    scSel = scdPkg::scHold;
  endtask

  task automatic testAdFlags();
    clearFlags();
    setAdFlags = 1'b1;
    adOv = 1'b1;
    adCry0 = 1'b1;
    adCry1 = 1'b1;
    piCycle = 1'b1;
    nextCycle();
    checkFlags("AD during PI cycle", 7'b0000000);
    piCycle = 1'b0;
    adCry0 = 1'b0;
    adCry1 = 1'b0;
    nextCycle();
    checkFlags("AD sets OV", 7'b1000000);
    adOv = 1'b0;
    adCry0 = 1'b1;
    nextCycle();
    checkFlags("AD sets CRY0", 7'b1100000);
    adCry0 = 1'b0;
    adCry1 = 1'b1;
    nextCycle();
    checkFlags("AD sets CRY1", 7'b1110000);
    setAdFlags = 1'b0;
    adCry1 = 1'b0;
    repeat (3) nextCycle();
    checkFlags("AD flags sticky", 7'b1110000);
  endtask

  task automatic testLoadTestMagic();
    logic [0:6] expected;
    magic = 9'h1FF;
    for (int i = 0; i < 4; i++) begin
      ar = {4'($urandom()), $urandom()};
      loadFlags = 1'b1;
      // The last load has a magic set beside it, which loses
      pcfMagic = (i == 3);
      expected = {ar[0], ar[1], ar[2], ar[3], ar[11], ar[12], ar[4]};
      nextCycle();
      checkFlags("load from AR", expected);
    end
    pcfMagic = 1'b0;
    clearFlags();
    scadASel = scdPkg::aMagic;
    scadFunc = scdPkg::funcA;
    magic = 9'h1C0;
    expTest = 1'b1;
    nextCycle();
    checkFlags("exponent test bits 0 and 1", 7'b1001100);
    expTest = 1'b0;
    clearFlags();
    // OR of arPos and arExpRaw sets SCAD bit 1 but not bit 0
    scadASel = scdPkg::aArPos;
    scadBSel = scdPkg::bArExpRaw;
    scadFunc = scdPkg::funcOr;
    ar[0] = 1'b1;
    expTest = 1'b1;
    nextCycle();
    checkFlags("exponent test bit 1", 7'b1001000);
    expTest = 1'b0;
    for (int i = 0; i < 9; i++) begin
      clearFlags();
      magic = 9'h100 >> i;
      pcfMagic = 1'b1;
      expected = {i == 0, 1'b0, 1'b0, i == 0, i == 5, i == 6, i == 2};
      nextCycle();
      pcfMagic = 1'b0;
      checkFlags("magic set", expected);
    end
    magic = 9'h040;
    pcfMagic = 1'b1;
    clrFpd = 1'b1;
    nextCycle();
    checkFlag("FPD set beats clear", 1'b1, fpd);
    pcfMagic = 1'b0;
    nextCycle();
    checkFlag("FPD cleared", 1'b0, fpd);
    clrFpd = 1'b0;
  endtask

  task automatic testReset();
    ar = '1;
    loadFlags = 1'b1;
    magic = 9'h0AA;
    scadASel = scdPkg::aMagic;
    scadFunc = scdPkg::funcA;
    feLoad = 1'b1;
    scSel = scdPkg::scArRight;
    nextCycle();
    checkFlags("before reset", 7'b1111111);
    checkWord("before reset fe", 10'h0AA, fe);
    checkWord("before reset sc", 10'h3FF, sc);
    reset = 1'b1;
    nextCycle();
    reset = 1'b0;
    clearControls();
    checkWord("reset fe", '0, fe);
    checkWord("reset sc", '0, sc);
    checkDecode("reset scGe36", 1'b0, scGe36);
    checkFlags("reset flags", 7'b0000000);
  endtask

  initial begin
    void'($urandom(38));
    clearControls();
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    testFunctions();
    testOperands();
    testScSources();
    testAdFlags();
    testLoadTestMagic();
    testReset();
    if (scdTop_i.scdAssertions_i.failureCount != 0) begin
      failRun("a bound assertion on the DUT failed");
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== scdTop.f ====
logic/scdPkg.sv
logic/scdCtlIf.sv
logic/scadOperandSelect.sv
logic/scadAdder.sv
logic/shiftCountRegs.sv
logic/arithFlags.sv
logic/scdTop.sv
dv/scd_assertions.sv
dv/scdTopTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := scdTopTb
FILELIST  := scdTop.f
FLAGS     := --binary --timing --assert
OBJ_DIR   := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
